// File: design/c64_loader_macros.svh
/*
 * Loader constants
 * File indices from the host, storage bases in external memory,
 * cartridge header offsets and the tape FIFO depth
 */
`ifndef C64_LOADER_MACROS_SVH
`define C64_LOADER_MACROS_SVH

// File indices sent by the host
`define C64_PRG_INDEX       8'h02
`define C64_CRT_INDEX       8'h03
`define C64_CRT_ALT_INDEX   8'hC0
`define C64_TAP_INDEX       8'h04

// Storage bases in external memory
`define C64_CRT_BASE        25'h100000
`define C64_TAP_BASE        25'h200000

// Cartridge header layout
// Exrom and game sit at the two offsets after the id
`define C64_CRT_ID_OFS      25'h016
`define C64_CRT_CHIP_START  25'h040
`define C64_CHIP_HDR_LEN    32'd16
`define C64_BANK_ALIGN_BITS 13

`define C64_TAPE_FIFO_DEPTH 16

`endif

// File: design/c64_loader_pkg.sv
/*
 * Loader types
 * Vector types for addresses, data and header fields,
 * and the FSM encodings of the parser and the memory arbiter
 */
package c64_loader_pkg;

	// Byte address into external memory
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  byte_t;
	// Big-endian fields of the cartridge header
	typedef logic [15:0] word16_t;
	typedef logic [31:0] blk_len_t;

	// Chip packet parsing in a cartridge image
	typedef enum logic [1:0] {
		CHIP_SYNC,
		CHIP_HEADER,
		CHIP_PAYLOAD
	} chip_state_t;

	// Owner of the current bus cycle
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE,
		ARB_READ
	} arb_state_t;

endpackage

// File: design/download_parser.sv
/*
 * Download parser
 * Turns the host byte stream into memory write requests, captures the
 * cartridge header and reports one bank record per chip packet
 */
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module download_parser
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      dl_active_i,
	input  byte_t     dl_index_i,
	input  logic      dl_wr_i,
	input  mem_addr_t dl_addr_i,
	input  byte_t     dl_data_i,
	input  logic      wr_done_i,
	input  logic      cart_detach_i,
	output logic      wr_req_o,
	output mem_addr_t wr_addr_o,
	output byte_t     wr_data_o,
	output word16_t   cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,
	output logic      cart_attached_o,
	output logic      bank_wr_o,
	output byte_t     bank_type_o,
	output word16_t   bank_num_o,
	output word16_t   bank_laddr_o,
	output word16_t   bank_size_o,
	output mem_addr_t bank_base_o,
	output logic      tape_loaded_o,
	output mem_addr_t tape_end_addr_o
);

	localparam mem_addr_t ALIGN_MASK = mem_addr_t'((1 << `C64_BANK_ALIGN_BITS) - 1);

	logic        is_prg;
	logic        is_crt;
	logic        is_tap;
	logic        old_active;
	logic        dl_end;
	logic        in_chips;
	logic        chip_sync;
	logic        chip_hdr;
	logic        chip_data;
	logic        store_byte;
	mem_addr_t   load_addr;
	mem_addr_t   store_addr;
	mem_addr_t   aligned_addr;
	chip_state_t chip_state;
	logic [3:0]  hdr_cnt;
	blk_len_t    blk_len;

	assign is_prg = (dl_index_i == `C64_PRG_INDEX);
	assign is_crt = (dl_index_i == `C64_CRT_INDEX) || (dl_index_i == `C64_CRT_ALT_INDEX);
	assign is_tap = (dl_index_i == `C64_TAP_INDEX);
	assign dl_end = old_active && !dl_active_i;

	// Chip packets start after the fixed cartridge header
	assign in_chips  = dl_wr_i && is_crt && (dl_addr_i >= `C64_CRT_CHIP_START);
	assign chip_sync = in_chips && (chip_state == CHIP_SYNC);
	assign chip_hdr  = in_chips && (chip_state == CHIP_HEADER);
	assign chip_data = in_chips && (chip_state == CHIP_PAYLOAD);

	// Program bytes 0 and 1 carry the load address and are not stored
	assign store_byte = (dl_wr_i && is_prg && dl_addr_i > 25'd1) ||
		(dl_wr_i && is_tap) || chip_data;

	// Tape data is stored from its base starting with the first byte
	assign store_addr   = (is_tap && dl_addr_i == '0) ? `C64_TAP_BASE : load_addr;
	assign aligned_addr = (load_addr + ALIGN_MASK) & ~ALIGN_MASK;

	// ==========================================================
	// Control: write request, chip FSM, status pulses
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			old_active      <= 1'b0;
			wr_req_o        <= 1'b0;
			bank_wr_o       <= 1'b0;
			tape_loaded_o   <= 1'b0;
			cart_attached_o <= 1'b0;
			chip_state      <= CHIP_SYNC;
			hdr_cnt         <= '0;
		end else begin
			old_active    <= dl_active_i;
			bank_wr_o     <= 1'b0;
			tape_loaded_o <= dl_end && is_tap;

			if (wr_done_i) begin
				wr_req_o <= 1'b0;
			end
			if (store_byte) begin
				wr_req_o <= 1'b1;
			end

			// New cartridge image restarts the packet parser
			if (dl_wr_i && is_crt && dl_addr_i == '0) begin
				chip_state <= CHIP_SYNC;
				hdr_cnt    <= '0;
			end
			if (chip_sync) begin
				chip_state <= CHIP_HEADER;
				hdr_cnt    <= 4'd1;
			end
			if (chip_hdr) begin
				hdr_cnt <= hdr_cnt + 4'd1;
				if (hdr_cnt == 4'd15) begin
					bank_wr_o  <= 1'b1;
					chip_state <= (blk_len == '0) ? CHIP_SYNC : CHIP_PAYLOAD;
				end
			end
			if (chip_data && blk_len == blk_len_t'(1)) begin
				chip_state <= CHIP_SYNC;
			end

			// Attached once a cartridge download completes
			if (dl_active_i != old_active && is_crt) begin
				cart_attached_o <= old_active;
			end
			if (cart_detach_i) begin
				cart_attached_o <= 1'b0;
			end
		end
	end

	// ==========================================================
	// Load address, header fields and write payload
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (store_byte) begin
			wr_addr_o <= store_addr;
			wr_data_o <= dl_data_i;
			load_addr <= store_addr + 25'd1;
		end

		if (dl_wr_i && is_prg) begin
			if (dl_addr_i == 25'd0) begin
				load_addr <= mem_addr_t'(dl_data_i);
			end
			if (dl_addr_i == 25'd1) begin
				load_addr <= {9'd0, dl_data_i, load_addr[7:0]};
			end
		end

		if (dl_wr_i && is_crt) begin
			case (dl_addr_i)
				25'd0:                   load_addr       <= `C64_CRT_BASE;
				`C64_CRT_ID_OFS:         cart_id_o[15:8] <= dl_data_i;
				`C64_CRT_ID_OFS + 25'd1: cart_id_o[7:0]  <= dl_data_i;
				`C64_CRT_ID_OFS + 25'd2: cart_exrom_o    <= dl_data_i;
				`C64_CRT_ID_OFS + 25'd3: cart_game_o     <= dl_data_i;
				default: ;
			endcase
		end

		// Each payload starts on an 8 KB boundary
		if (chip_sync) begin
			load_addr <= aligned_addr;
		end

		if (chip_hdr) begin
			case (hdr_cnt)
				4'd4:  blk_len[31:24]      <= dl_data_i;
				4'd5:  blk_len[23:16]      <= dl_data_i;
				4'd6:  blk_len[15:8]       <= dl_data_i;
				4'd7:  blk_len[7:0]        <= dl_data_i;
				4'd8:  blk_len             <= blk_len - `C64_CHIP_HDR_LEN;
				4'd9:  bank_type_o         <= dl_data_i;
				4'd10: bank_num_o[15:8]    <= dl_data_i;
				4'd11: bank_num_o[7:0]     <= dl_data_i;
				4'd12: bank_laddr_o[15:8]  <= dl_data_i;
				4'd13: bank_laddr_o[7:0]   <= dl_data_i;
				4'd14: bank_size_o[15:8]   <= dl_data_i;
				4'd15: begin
					bank_size_o[7:0] <= dl_data_i;
					bank_base_o      <= load_addr;
				end
				default: ;
			endcase
		end

		if (chip_data) begin
			blk_len <= blk_len - blk_len_t'(1);
		end

		// Next free address marks the end of the tape
		if (dl_end && is_tap) begin
			tape_end_addr_o <= load_addr;
		end
	end

endmodule

// File: design/mem_arbiter.sv
/*
 * Memory arbiter
 * Wishbone classic master shared by parser writes and tape reads,
 * one transfer at a time with writes served first
 */
`timescale 1ns/1ps

module mem_arbiter
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      wr_req_i,
	input  mem_addr_t wr_addr_i,
	input  byte_t     wr_data_i,
	input  logic      rd_req_i,
	input  mem_addr_t rd_addr_i,
	input  byte_t     mem_dat_i,
	input  logic      mem_ack_i,
	output logic      wr_done_o,
	output logic      rd_done_o,
	output byte_t     rd_data_o,
	output logic      mem_cyc_o,
	output logic      mem_stb_o,
	output logic      mem_we_o,
	output mem_addr_t mem_adr_o,
	output byte_t     mem_dat_o
);

	arb_state_t state;

	// Done follows the ack directly, so the requester drops its request
	// on the same edge the arbiter returns to idle
	assign wr_done_o = (state == ARB_WRITE) && mem_ack_i;
	assign rd_done_o = (state == ARB_READ) && mem_ack_i;
	assign rd_data_o = mem_dat_i;

	// Strobe always matches cycle for single transfers
	assign mem_stb_o = mem_cyc_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state     <= ARB_IDLE;
			mem_cyc_o <= 1'b0;
			mem_we_o  <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (wr_req_i) begin
						state     <= ARB_WRITE;
						mem_cyc_o <= 1'b1;
						mem_we_o  <= 1'b1;
					end else if (rd_req_i) begin
						state     <= ARB_READ;
						mem_cyc_o <= 1'b1;
					end
				end
				ARB_WRITE, ARB_READ: begin
					if (mem_ack_i) begin
						state     <= ARB_IDLE;
						mem_cyc_o <= 1'b0;
						mem_we_o  <= 1'b0;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Address and data latch only when a transfer starts
	always_ff @(posedge clk_sys) begin
		if (state == ARB_IDLE) begin
			if (wr_req_i) begin
				mem_adr_o <= wr_addr_i;
				mem_dat_o <= wr_data_i;
			end else if (rd_req_i) begin
				mem_adr_o <= rd_addr_i;
			end
		end
	end

endmodule

// File: design/tape_fetch.sv
/*
 * Tape fetch
 * Play/stop control and read address generation for tape playback
 */
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module tape_fetch
	import c64_loader_pkg::*;
(
	input  logic                                 clk_sys,
	input  logic                                 reset_n,
	input  logic                                 play_btn_i,
	input  logic                                 tape_loaded_i,
	input  mem_addr_t                            tape_end_addr_i,
	input  logic                                 rd_done_i,
	input  logic [$clog2(`C64_TAPE_FIFO_DEPTH):0] fifo_count_i,
	output logic                                 rd_req_o,
	output mem_addr_t                            rd_addr_o,
	output logic                                 tape_playing_o
);

	mem_addr_t last_addr;
	logic      play_btn_d;
	logic      can_fetch;

	// Only one read is ever in flight and a new one starts after the
	// previous byte is counted, so a free slot covers it
	assign can_fetch = tape_playing_o && (rd_addr_o < last_addr) &&
		(fifo_count_i < ($clog2(`C64_TAPE_FIFO_DEPTH) + 1)'(`C64_TAPE_FIFO_DEPTH));

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			rd_req_o       <= 1'b0;
			rd_addr_o      <= `C64_TAP_BASE;
			last_addr      <= `C64_TAP_BASE;
			tape_playing_o <= 1'b0;
			play_btn_d     <= 1'b0;
		end else begin
			play_btn_d <= play_btn_i;
			if (play_btn_i && !play_btn_d) begin
				tape_playing_o <= !tape_playing_o;
			end

			// A read in flight always completes, even after stop
			if (rd_done_i) begin
				rd_req_o  <= 1'b0;
				rd_addr_o <= rd_addr_o + 25'd1;
			end else if (!rd_req_o && can_fetch) begin
				rd_req_o <= 1'b1;
			end

			// Fresh tape rewinds and starts playing
			if (tape_loaded_i) begin
				rd_addr_o      <= `C64_TAP_BASE;
				last_addr      <= tape_end_addr_i;
				tape_playing_o <= 1'b1;
			end
		end
	end

endmodule

// File: design/tape_fifo.sv
/*
 * Tape FIFO
 * First-word-fallthrough byte buffer between tape reads and the consumer
 */
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module tape_fifo
	import c64_loader_pkg::*;
#(
	parameter int DEPTH = `C64_TAPE_FIFO_DEPTH
) (
	input  logic                  clk_sys,
	input  logic                  reset_n,
	input  logic                  flush_i,
	input  logic                  push_i,
	input  byte_t                 push_data_i,
	input  logic                  pop_i,
	output logic                  valid_o,
	output byte_t                 data_o,
	output logic [$clog2(DEPTH):0] count_o
);

	localparam int AW = $clog2(DEPTH);

	byte_t         mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          do_push;
	logic          do_pop;

	// Head entry is always on the output
	assign valid_o = (count_o != '0);
	assign data_o  = mem[rd_ptr];
	assign do_push = push_i && (count_o != (AW + 1)'(DEPTH));
	assign do_pop  = pop_i && valid_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n || flush_i) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_o <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count_o <= count_o + 1'b1;
				2'b01:   count_o <= count_o - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

endmodule

// File: design/c64_loader_top.sv
/*
 * Loader top level
 * Host download parsing, tape playback and one shared Wishbone master
 */
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module c64_loader_top
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	// Host download port
	input  logic      dl_active_i,
	input  byte_t     dl_index_i,
	input  logic      dl_wr_i,
	input  mem_addr_t dl_addr_i,
	input  byte_t     dl_data_i,
	output logic      dl_wait_o,
	// Wishbone master
	output logic      mem_cyc_o,
	output logic      mem_stb_o,
	output logic      mem_we_o,
	output mem_addr_t mem_adr_o,
	output byte_t     mem_dat_o,
	input  byte_t     mem_dat_i,
	input  logic      mem_ack_i,
	// Cartridge
	input  logic      cart_detach_i,
	output word16_t   cart_id_o,
	output byte_t     cart_exrom_o,
	output byte_t     cart_game_o,
	output logic      cart_attached_o,
	output logic      bank_wr_o,
	output byte_t     bank_type_o,
	output word16_t   bank_num_o,
	output word16_t   bank_laddr_o,
	output word16_t   bank_size_o,
	output mem_addr_t bank_base_o,
	// Tape
	input  logic      play_btn_i,
	input  logic      tape_rd_i,
	output logic      tape_valid_o,
	output byte_t     tape_data_o,
	output logic      tape_playing_o
);

	logic      wr_req;
	mem_addr_t wr_addr;
	byte_t     wr_data;
	logic      wr_done;
	logic      rd_req;
	mem_addr_t rd_addr;
	logic      rd_done;
	byte_t     rd_data;
	logic      tape_loaded;
	mem_addr_t tape_end_addr;
	logic [$clog2(`C64_TAPE_FIFO_DEPTH):0] fifo_count;

	// Host waits while a parser write is pending
	assign dl_wait_o = wr_req;

	// ==========================================================
	// Download and memory
	// ==========================================================
	download_parser u_parser (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.wr_done_i       (wr_done),
		.cart_detach_i   (cart_detach_i),
		.wr_req_o        (wr_req),
		.wr_addr_o       (wr_addr),
		.wr_data_o       (wr_data),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.cart_attached_o (cart_attached_o),
		.bank_wr_o       (bank_wr_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_base_o     (bank_base_o),
		.tape_loaded_o   (tape_loaded),
		.tape_end_addr_o (tape_end_addr)
	);

	mem_arbiter u_arbiter (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.wr_req_i  (wr_req),
		.wr_addr_i (wr_addr),
		.wr_data_i (wr_data),
		.rd_req_i  (rd_req),
		.rd_addr_i (rd_addr),
		.mem_dat_i (mem_dat_i),
		.mem_ack_i (mem_ack_i),
		.wr_done_o (wr_done),
		.rd_done_o (rd_done),
		.rd_data_o (rd_data),
		.mem_cyc_o (mem_cyc_o),
		.mem_stb_o (mem_stb_o),
		.mem_we_o  (mem_we_o),
		.mem_adr_o (mem_adr_o),
		.mem_dat_o (mem_dat_o)
	);

	// ==========================================================
	// Tape playback
	// ==========================================================
	tape_fetch u_fetch (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.play_btn_i      (play_btn_i),
		.tape_loaded_i   (tape_loaded),
		.tape_end_addr_i (tape_end_addr),
		.rd_done_i       (rd_done),
		.fifo_count_i    (fifo_count),
		.rd_req_o        (rd_req),
		.rd_addr_o       (rd_addr),
		.tape_playing_o  (tape_playing_o)
	);

	// Read data goes straight in on the done cycle
	tape_fifo u_fifo (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.flush_i     (tape_loaded),
		.push_i      (rd_done),
		.push_data_i (rd_data),
		.pop_i       (tape_rd_i),
		.valid_o     (tape_valid_o),
		.data_o      (tape_data_o),
		.count_o     (fifo_count)
	);

endmodule

// File: dv/tb_wb_memory.sv
/*
 * Wishbone memory model
 * Byte-wide slave with a random ack delay and bus rule checks
 */
`timescale 1ns/1ps

module tb_wb_memory
	import c64_loader_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset_n,
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  mem_addr_t adr_i,
	input  byte_t     dat_i,
	output byte_t     dat_o,
	output logic      ack_o,
	output logic      bus_err_o
);

	byte_t     mem [mem_addr_t];
	integer    seed;
	int        delay;
	logic      busy;
	logic [1:0] wait_cnt;
	logic      prev_stb;
	logic      prev_ack;
	logic      prev_we;
	mem_addr_t prev_adr;
	byte_t     prev_dat;

	initial seed = 32'h5902_687e;

	// Unwritten locations return a pattern built from the whole address
	function automatic byte_t peek_byte(input mem_addr_t a);
		byte_t fill;
		fill = a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]};
		if (mem.exists(a)) begin
			return mem[a];
		end
		return fill;
	endfunction

	task automatic finish_transfer();
		ack_o <= 1'b1;
		busy  <= 1'b0;
		if (we_i) begin
			mem[adr_i] = dat_i;
		end else begin
			dat_o <= peek_byte(adr_i);
		end
	endtask

	// ============================================================
	// Slave response
	// ============================================================
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			ack_o    <= 1'b0;
			busy     <= 1'b0;
			wait_cnt <= '0;
			dat_o    <= '0;
		end else if (ack_o) begin
			ack_o <= 1'b0;
		end else if (stb_i && !busy) begin
			delay = $random(seed) & 3;
			if (delay == 0) begin
				finish_transfer();
			end else begin
				busy     <= 1'b1;
				wait_cnt <= 2'(delay - 1);
			end
		end else if (busy) begin
			if (wait_cnt == 0) begin
				finish_transfer();
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

	// ============================================================
	// Bus rule checks
	// ============================================================
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			bus_err_o <= 1'b0;
		end else begin
			assert (!(stb_i && !cyc_i)) else begin
				$display("Wishbone stb is high without cyc");
				bus_err_o <= 1'b1;
			end
			if (prev_stb && !prev_ack) begin
				assert (stb_i && adr_i == prev_adr && dat_i == prev_dat && we_i == prev_we)
				else begin
					$display("Wishbone request changed before ack");
					bus_err_o <= 1'b1;
				end
			end
			if (prev_ack) begin
				assert (!cyc_i && !stb_i) else begin
					$display("Wishbone cyc or stb still high the cycle after ack");
					bus_err_o <= 1'b1;
				end
			end
		end
		prev_stb <= stb_i;
		prev_ack <= ack_o;
		prev_we  <= we_i;
		prev_adr <= adr_i;
		prev_dat <= dat_i;
	end

endmodule

// File: dv/tb_c64_loader.sv
/*
 * Loader testbench
 * Streams program, cartridge and tape files into the DUT and checks
 * memory contents, cartridge fields and tape playback order
 */
`timescale 1ns/1ps
`include "c64_loader_macros.svh"

module tb_c64_loader
	import c64_loader_pkg::*;
();

	logic      clk_sys;
	logic      reset_n;
	logic      dl_active_i;
	byte_t     dl_index_i;
	logic      dl_wr_i;
	mem_addr_t dl_addr_i;
	byte_t     dl_data_i;
	logic      dl_wait_o;
	logic      mem_cyc_o;
	logic      mem_stb_o;
	logic      mem_we_o;
	mem_addr_t mem_adr_o;
	byte_t     mem_dat_o;
	byte_t     mem_dat_i;
	logic      mem_ack_i;
	logic      cart_detach_i;
	word16_t   cart_id_o;
	byte_t     cart_exrom_o;
	byte_t     cart_game_o;
	logic      cart_attached_o;
	logic      bank_wr_o;
	byte_t     bank_type_o;
	word16_t   bank_num_o;
	word16_t   bank_laddr_o;
	word16_t   bank_size_o;
	mem_addr_t bank_base_o;
	logic      play_btn_i;
	logic      tape_rd_i;
	logic      tape_valid_o;
	byte_t     tape_data_o;
	logic      tape_playing_o;
	logic      bus_err;

	integer    seed = 32'h5902_687e;
	byte_t     crt_img [0:127];
	byte_t     tape_img [0:39];
	byte_t     prg_img [0:13];
	logic [7:0]  rec_type [0:3];
	logic [15:0] rec_num [0:3];
	logic [15:0] rec_laddr [0:3];
	logic [15:0] rec_size [0:3];
	mem_addr_t   rec_base [0:3];
	int          bank_cnt;

	c64_loader_top uut (.*, .mem_dat_i(mem_dat_i), .mem_ack_i(mem_ack_i));

	tb_wb_memory wbm (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.cyc_i     (mem_cyc_o),
		.stb_i     (mem_stb_o),
		.we_i      (mem_we_o),
		.adr_i     (mem_adr_o),
		.dat_i     (mem_dat_o),
		.dat_o     (mem_dat_i),
		.ack_o     (mem_ack_i),
		.bus_err_o (bus_err)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic fail_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp == act) else begin
			$display("Mismatch %s expected %0h actual %0h", name, exp, act);
			fail_run();
		end
	endtask

	// Host side rule and the bus model flag
	always @(posedge clk_sys) begin
		if (reset_n) begin
			assert (!(dl_wr_i && dl_wait_o)) else begin
				$display("Host strobed a byte while dl_wait_o was high");
				fail_run();
			end
			assert (!bus_err) else begin
				$display("Wishbone bus rule broken");
				fail_run();
			end
		end
	end

	// Bank records as reported by the parser
	always @(posedge clk_sys) begin
		if (!reset_n) begin
			bank_cnt = 0;
		end else if (bank_wr_o && bank_cnt < 4) begin
			rec_type[bank_cnt]  = bank_type_o;
			rec_num[bank_cnt]   = bank_num_o;
			rec_laddr[bank_cnt] = bank_laddr_o;
			rec_size[bank_cnt]  = bank_size_o;
			rec_base[bank_cnt]  = bank_base_o;
			bank_cnt = bank_cnt + 1;
		end
	end

	task automatic send_byte(input int ofs, input byte_t data);
		int t;
		t = 0;
		@(posedge clk_sys);
		dl_wr_i   <= 1'b1;
		dl_addr_i <= mem_addr_t'(ofs);
		dl_data_i <= data;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		@(negedge clk_sys);
		while (dl_wait_o) begin
			t = t + 1;
			if (t > 200) begin
				$display("Download stalled, dl_wait_o stayed high");
				fail_run();
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic begin_download(input byte_t idx);
		@(posedge clk_sys);
		dl_index_i  <= idx;
		dl_active_i <= 1'b1;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic pulse_play();
		@(posedge clk_sys);
		play_btn_i <= 1'b1;
		@(posedge clk_sys);
		play_btn_i <= 1'b0;
	endtask

	task automatic wait_playing(input logic want);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (tape_playing_o != want) begin
			t = t + 1;
			if (t > 100) begin
				$display("tape_playing_o never reached the expected level");
				fail_run();
			end
			@(negedge clk_sys);
		end
	endtask

	// Pops one byte after a random pause and returns the head entry
	task automatic pop_byte(output byte_t d);
		int t;
		t = 0;
		@(negedge clk_sys);
		while (!tape_valid_o) begin
			t = t + 1;
			if (t > 500) begin
				$display("Tape FIFO never delivered a byte");
				fail_run();
			end
			@(negedge clk_sys);
		end
		repeat ($random(seed) & 3) @(posedge clk_sys);
		@(posedge clk_sys);
		tape_rd_i <= 1'b1;
		@(negedge clk_sys);
		d = tape_data_o;
		@(posedge clk_sys);
		tape_rd_i <= 1'b0;
	endtask

	task automatic put_chip(input int at, input byte_t typ, input logic [15:0] num,
		input logic [15:0] laddr, input logic [15:0] size, input int plen);
		int len;
		len = 16 + plen;
		crt_img[at]      = "C";
		crt_img[at + 1]  = "H";
		crt_img[at + 2]  = "I";
		crt_img[at + 3]  = "P";
		crt_img[at + 4]  = len[31:24];
		crt_img[at + 5]  = len[23:16];
		crt_img[at + 6]  = len[15:8];
		crt_img[at + 7]  = len[7:0];
		crt_img[at + 8]  = 8'h00;
		crt_img[at + 9]  = typ;
		crt_img[at + 10] = num[15:8];
		crt_img[at + 11] = num[7:0];
		crt_img[at + 12] = laddr[15:8];
		crt_img[at + 13] = laddr[7:0];
		crt_img[at + 14] = size[15:8];
		crt_img[at + 15] = size[7:0];
		for (int i = 0; i < plen; i++) begin
			crt_img[at + 16 + i] = $random(seed);
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		byte_t     d;
		int        tape_pos;
		int        quiet;
		int        t;
		mem_addr_t base2;

		reset_n       <= 1'b0;
		dl_active_i   <= 1'b0;
		dl_index_i    <= '0;
		dl_wr_i       <= 1'b0;
		dl_addr_i     <= '0;
		dl_data_i     <= '0;
		cart_detach_i <= 1'b0;
		play_btn_i    <= 1'b0;
		tape_rd_i     <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reset_n <= 1'b1;

		@(negedge clk_sys);
		check_value("reset dl_wait", 0, dl_wait_o);
		check_value("reset mem_cyc", 0, mem_cyc_o);
		check_value("reset mem_stb", 0, mem_stb_o);
		check_value("reset mem_we", 0, mem_we_o);
		check_value("reset bank_wr", 0, bank_wr_o);
		check_value("reset tape_valid", 0, tape_valid_o);
		check_value("reset tape_playing", 0, tape_playing_o);
		check_value("reset cart_attached", 0, cart_attached_o);

		// Program file loading at 0801
		prg_img[0] = 8'h01;
		prg_img[1] = 8'h08;
		for (int i = 2; i < 14; i++) begin
			prg_img[i] = $random(seed);
		end
		begin_download(`C64_PRG_INDEX);
		for (int i = 0; i < 14; i++) begin
			send_byte(i, prg_img[i]);
		end
		end_download();
		for (int i = 2; i < 14; i++) begin
			check_value("prg memory", prg_img[i], wbm.peek_byte(mem_addr_t'(16'h0801 + i - 2)));
		end

		// Cartridge with two chips where the first payload is odd
		for (int i = 0; i < 64; i++) begin
			crt_img[i] = $random(seed);
		end
		put_chip(64, 8'h01, 16'h0000, 16'h8000, 16'h2000, 5);
		put_chip(85, 8'h02, 16'h0001, 16'hA000, 16'h4000, 4);
		begin_download(`C64_CRT_INDEX);
		for (int i = 0; i < 105; i++) begin
			send_byte(i, crt_img[i]);
		end
		end_download();
		t = 0;
		while (!cart_attached_o) begin
			t = t + 1;
			if (t > 50) begin
				$display("cart_attached_o did not rise after the cartridge download");
				fail_run();
			end
			@(negedge clk_sys);
		end
		check_value("cart id", {crt_img[22], crt_img[23]}, cart_id_o);
		check_value("cart exrom", crt_img[24], cart_exrom_o);
		check_value("cart game", crt_img[25], cart_game_o);
		check_value("bank count", 2, bank_cnt);
		// Five payload bytes push the second chip into the next 8 KB bank
		base2 = `C64_CRT_BASE + 25'h2000;
		check_value("bank0 type", 8'h01, rec_type[0]);
		check_value("bank0 num", 16'h0000, rec_num[0]);
		check_value("bank0 laddr", 16'h8000, rec_laddr[0]);
		check_value("bank0 size", 16'h2000, rec_size[0]);
		check_value("bank0 base", `C64_CRT_BASE, rec_base[0]);
		check_value("bank1 type", 8'h02, rec_type[1]);
		check_value("bank1 num", 16'h0001, rec_num[1]);
		check_value("bank1 laddr", 16'hA000, rec_laddr[1]);
		check_value("bank1 size", 16'h4000, rec_size[1]);
		check_value("bank1 base", base2, rec_base[1]);
		for (int i = 0; i < 5; i++) begin
			check_value("chip0 payload", crt_img[80 + i], wbm.peek_byte(`C64_CRT_BASE + 25'(i)));
		end
		for (int i = 0; i < 4; i++) begin
			check_value("chip1 payload", crt_img[101 + i], wbm.peek_byte(base2 + 25'(i)));
		end
		@(posedge clk_sys);
		cart_detach_i <= 1'b1;
		@(posedge clk_sys);
		cart_detach_i <= 1'b0;
		@(negedge clk_sys);
		check_value("cart detach", 0, cart_attached_o);

		// Tape load and playback with a stop and resume in the middle
		for (int i = 0; i < 40; i++) begin
			tape_img[i] = $random(seed);
		end
		begin_download(`C64_TAP_INDEX);
		for (int i = 0; i < 40; i++) begin
			send_byte(i, tape_img[i]);
		end
		end_download();
		wait_playing(1'b1);
		// No pops for long enough that the FIFO fills and fetching pauses
		repeat (160) @(posedge clk_sys);
		tape_pos = 0;
		for (int i = 0; i < 10; i++) begin
			pop_byte(d);
			check_value("tape order", tape_img[tape_pos], d);
			tape_pos = tape_pos + 1;
		end

		pulse_play();
		wait_playing(1'b0);
		quiet = 0;
		t = 0;
		while (quiet < 20) begin
			@(negedge clk_sys);
			t = t + 1;
			if (t > 1000) begin
				$display("Tape FIFO kept delivering after stop");
				fail_run();
			end
			if (tape_valid_o) begin
				quiet = 0;
				pop_byte(d);
				check_value("tape order after stop", tape_img[tape_pos], d);
				tape_pos = tape_pos + 1;
			end else begin
				quiet = quiet + 1;
			end
		end
		if (tape_pos >= 40) begin
			$display("Stop did not pause tape fetching");
			fail_run();
		end
		repeat (30) begin
			@(negedge clk_sys);
			check_value("tape valid while stopped", 0, tape_valid_o);
		end

		pulse_play();
		wait_playing(1'b1);
		while (tape_pos < 40) begin
			pop_byte(d);
			check_value("tape order after resume", tape_img[tape_pos], d);
			tape_pos = tape_pos + 1;
		end
		repeat (50) begin
			@(negedge clk_sys);
			check_value("tape valid after end", 0, tape_valid_o);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+design
design/c64_loader_pkg.sv
design/download_parser.sv
design/mem_arbiter.sv
design/tape_fetch.sv
design/tape_fifo.sv
design/c64_loader_top.sv
dv/tb_wb_memory.sv
dv/tb_c64_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f \
	--top-module tb_c64_loader -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Compilation failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
exit 1
